// File: include/dct_params.svh
`ifndef DCT_PARAMS_SVH
`define DCT_PARAMS_SVH

// Pixel and block geometry
`define DCT_PIX_W        8
`define DCT_N            8

// Fixed point scaling of the cosine table and of both rounding steps
`define DCT_COEF_FRAC    14
`define DCT_ROW_DROP     12
`define DCT_COL_DROP     16
`define DCT_OUT_W        11

// Flow control limits
`define DCT_IN_CREDITS   8
`define DCT_OUT_CREDITS  8
`define DCT_BANKS        2

`endif

// File: logic/dct_math_pkg.sv
`default_nettype none

`include "dct_params.svh"

package dct_math_pkg;

    typedef logic [`DCT_PIX_W-1:0]                         pixel_t;
    typedef logic signed [`DCT_COEF_FRAC+1:0]              coef_t;
    typedef logic signed [24:0]                            row_acc_t;
    typedef logic signed [$bits(row_acc_t)-`DCT_ROW_DROP-1:0] row_val_t;
    typedef logic signed [31:0]                            col_acc_t;
    typedef logic signed [`DCT_OUT_W-1:0]                  dct_out_t;
    typedef row_val_t [`DCT_N-1:0]                         row_vec_t;
    // Element v*N+u holds vertical frequency v, horizontal frequency u
    typedef dct_out_t [`DCT_N*`DCT_N-1:0]                  block_t;

    // C[k][n], scaled by 2^14 and halved
    function automatic coef_t dct_coef(input logic [2:0] k, input logic [2:0] n);
        logic [4:0] m;
        logic [4:0] f;
        coef_t      mag;
        // Angle in units of pi/16, folded into the first half turn
        m = {1'b0, n, 1'b1} * {2'b00, k};
        f = (m > 5'd16) ? 5'd0 - m : m;
        case ((f > 5'd8) ? 5'd16 - f : f)
            5'd1:    mag = coef_t'(8035);
            5'd2:    mag = coef_t'(7568);
            5'd3:    mag = coef_t'(6811);
            5'd4:    mag = coef_t'(5793);
            5'd5:    mag = coef_t'(4551);
            5'd6:    mag = coef_t'(3135);
            5'd7:    mag = coef_t'(1598);
            default: mag = '0;
        endcase
        if (k == 3'd0) begin
            return coef_t'(5793);
        end
        return (f > 5'd8) ? -mag : mag;
    endfunction

endpackage

`default_nettype wire

// File: logic/dct_flow_pkg.sv
`default_nettype none

`include "dct_params.svh"

package dct_flow_pkg;

    // Row or column inside a block
    typedef logic [$clog2(`DCT_N)-1:0]          idx_t;

    // Raster position inside a block
    typedef logic [$clog2(`DCT_N*`DCT_N)-1:0]   pos_t;

    // Sized to hold the full credit limit
    typedef logic [$clog2(`DCT_IN_CREDITS):0]   credit_t;

    typedef logic [$clog2(`DCT_BANKS):0]        bank_cnt_t;

endpackage

`default_nettype wire

// File: logic/dct_link_if.sv
`default_nettype none

interface dct_link_if;
    import dct_math_pkg::*;
    import dct_flow_pkg::*;

    // Row vectors from the row pass
    logic      row_valid;
    row_vec_t  row_vec;
    idx_t      row_idx;

    // Block admission handshake
    logic      block_open;
    logic      block_start;

    // Finished blocks into the output buffer
    logic      blk_valid;
    block_t    blk_data;
    bank_cnt_t free_banks;

    modport row_src (
        output row_valid, row_vec, row_idx, block_start,
        input  block_open
    );

    modport row_dst (
        input  row_valid, row_vec, row_idx, block_start,
        output block_open
    );

    modport blk_src (
        output blk_valid, blk_data,
        input  free_banks
    );

    modport blk_dst (
        input  blk_valid, blk_data,
        output free_banks
    );

endinterface

`default_nettype wire

// File: logic/row_transform.sv
`default_nettype none

`include "dct_params.svh"

module row_transform (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pix_valid,
    input  dct_math_pkg::pixel_t pix_data,
    output logic                 pix_credit,
    dct_link_if.row_src          lnk
);
    import dct_math_pkg::*;
    import dct_flow_pkg::*;

    credit_t                       credits_out;
    pos_t                          grant_pos;
    logic                          blk_active;
    logic                          grant;
    idx_t                          col;
    idx_t                          row;
    idx_t                          done_row;
    logic                          row_done;
    logic signed [`DCT_PIX_W-1:0]  shifted;
    row_acc_t                      prod [`DCT_N];
    row_acc_t                      acc  [`DCT_N];

    // A new block may start once every credit of the current one is granted
    assign lnk.block_start = !blk_active && lnk.block_open;
    assign grant = (blk_active || lnk.block_start) && (credits_out < `DCT_IN_CREDITS);

    // Subtracting 128 only flips the pixel MSB
    assign shifted = {~pix_data[`DCT_PIX_W-1], pix_data[`DCT_PIX_W-2:0]};

    always_comb begin
        for (int k = 0; k < `DCT_N; k++) begin
            prod[k] = shifted * dct_coef(idx_t'(k), col);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix_credit  <= 1'b0;
            credits_out <= '0;
            grant_pos   <= '0;
            blk_active  <= 1'b0;
        end else begin
            pix_credit  <= grant;
            credits_out <= credits_out + credit_t'(grant) - credit_t'(pix_valid);
            if (grant) begin
                grant_pos  <= grant_pos + 1'b1;
                blk_active <= (grant_pos != pos_t'(`DCT_N*`DCT_N-1));
            end else if (lnk.block_start) begin
                blk_active <= 1'b1;
            end
        end
    end

    // Position of the next pixel to arrive
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            col      <= '0;
            row      <= '0;
            row_done <= 1'b0;
        end else begin
            row_done <= pix_valid && (col == idx_t'(`DCT_N-1));
            if (pix_valid) begin
                col <= col + 1'b1;
                if (col == idx_t'(`DCT_N-1)) begin
                    row <= row + 1'b1;
                end
            end
        end
    end

    // Eight running sums, restarted at column 0, then rounded
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            for (int k = 0; k < `DCT_N; k++) begin
                acc[k] <= (col == '0) ? prod[k] : acc[k] + prod[k];
            end
            if (col == idx_t'(`DCT_N-1)) begin
                done_row <= row;
            end
        end
        if (row_done) begin
            for (int k = 0; k < `DCT_N; k++) begin
                lnk.row_vec[k] <= acc[k][$bits(row_acc_t)-1:`DCT_ROW_DROP]
                                  + acc[k][`DCT_ROW_DROP-1];
            end
            lnk.row_idx <= done_row;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lnk.row_valid <= 1'b0;
        end else begin
            lnk.row_valid <= row_done;
        end
    end

    // Source must hold a credit for every pixel
    assert property (@(posedge clk) disable iff (rst) pix_valid |-> credits_out != '0)
        else $error("pixel received without an outstanding credit");

endmodule

`default_nettype wire

// File: logic/column_transform.sv
`default_nettype none

`include "dct_params.svh"

module column_transform (
    input  logic        clk,
    input  logic        rst,
    dct_link_if.row_dst lnk_row,
    dct_link_if.blk_src lnk_blk
);
    import dct_math_pkg::*;
    import dct_flow_pkg::*;

    col_acc_t  prod [`DCT_N][`DCT_N];
    col_acc_t  acc  [`DCT_N][`DCT_N];
    logic      blk_done;
    bank_cnt_t pending;
    idx_t      exp_row;

    // Every admitted block must find a free bank when it finishes
    assign lnk_row.block_open = (pending < lnk_blk.free_banks);

    // Row r contributes C[v][r] * Y_r[u] to coefficient (v, u)
    always_comb begin
        for (int v = 0; v < `DCT_N; v++) begin
            for (int u = 0; u < `DCT_N; u++) begin
                prod[v][u] = $signed(lnk_row.row_vec[u]) * dct_coef(idx_t'(v), lnk_row.row_idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lnk_row.row_valid) begin
            for (int v = 0; v < `DCT_N; v++) begin
                for (int u = 0; u < `DCT_N; u++) begin
                    acc[v][u] <= (lnk_row.row_idx == '0) ? prod[v][u]
                                                         : acc[v][u] + prod[v][u];
                end
            end
        end
        if (blk_done) begin
            for (int v = 0; v < `DCT_N; v++) begin
                for (int u = 0; u < `DCT_N; u++) begin
                    lnk_blk.blk_data[v*`DCT_N+u] <=
                        acc[v][u][`DCT_COL_DROP+`DCT_OUT_W-1:`DCT_COL_DROP]
                        + acc[v][u][`DCT_COL_DROP-1];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blk_done          <= 1'b0;
            lnk_blk.blk_valid <= 1'b0;
            pending           <= '0;
            exp_row           <= '0;
        end else begin
            blk_done          <= lnk_row.row_valid && (lnk_row.row_idx == idx_t'(`DCT_N-1));
            lnk_blk.blk_valid <= blk_done;
            // Admitted blocks not yet handed to the output buffer
            pending <= pending + bank_cnt_t'(lnk_row.block_start)
                       - bank_cnt_t'(lnk_blk.blk_valid);
            if (lnk_row.row_valid) begin
                exp_row <= exp_row + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        lnk_row.row_valid |-> lnk_row.row_idx == exp_row)
        else $error("row vector out of order");

endmodule

`default_nettype wire

// File: logic/coef_stream_out.sv
`default_nettype none

`include "dct_params.svh"

module coef_stream_out (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   coef_valid,
    output dct_math_pkg::dct_out_t coef_data,
    input  logic                   coef_credit,
    dct_link_if.blk_dst            lnk
);
    import dct_math_pkg::*;
    import dct_flow_pkg::*;

    localparam int BANK_W = ($clog2(`DCT_BANKS) > 0) ? $clog2(`DCT_BANKS) : 1;

    block_t            bank [`DCT_BANKS];
    logic [BANK_W-1:0] wr_bank;
    logic [BANK_W-1:0] rd_bank;
    pos_t              rd_pos;
    credit_t           credits;
    logic              send;
    logic              release_bank;

    assign send         = (lnk.free_banks != bank_cnt_t'(`DCT_BANKS)) && (credits != '0);
    assign release_bank = send && (rd_pos == pos_t'(`DCT_N*`DCT_N-1));

    always_ff @(posedge clk) begin
        if (lnk.blk_valid) begin
            bank[wr_bank] <= lnk.blk_data;
        end
        if (send) begin
            coef_data <= bank[rd_bank][rd_pos];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            coef_valid     <= 1'b0;
            wr_bank        <= '0;
            rd_bank        <= '0;
            rd_pos         <= '0;
            credits        <= '0;
            lnk.free_banks <= bank_cnt_t'(`DCT_BANKS);
        end else begin
            coef_valid <= send;
            if (lnk.blk_valid) begin
                wr_bank <= (wr_bank == BANK_W'(`DCT_BANKS-1)) ? '0 : wr_bank + 1'b1;
            end
            if (send) begin
                rd_pos <= rd_pos + 1'b1;
            end
            if (release_bank) begin
                rd_bank <= (rd_bank == BANK_W'(`DCT_BANKS-1)) ? '0 : rd_bank + 1'b1;
            end
            lnk.free_banks <= lnk.free_banks - bank_cnt_t'(lnk.blk_valid)
                              + bank_cnt_t'(release_bank);
            // Saturates at the limit
            if (coef_credit && !send && credits != credit_t'(`DCT_OUT_CREDITS)) begin
                credits <= credits + 1'b1;
            end else if (send && !coef_credit) begin
                credits <= credits - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) lnk.blk_valid |-> lnk.free_banks != '0)
        else $error("block written with no free bank");

    assert property (@(posedge clk) disable iff (rst)
        coef_credit && !send |-> credits != credit_t'(`DCT_OUT_CREDITS))
        else $error("sink granted more output credits than the limit");

endmodule

`default_nettype wire

// File: logic/dct_top.sv
`default_nettype none

module dct_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pix_valid,
    input  dct_math_pkg::pixel_t   pix_data,
    output logic                   pix_credit,
    output logic                   coef_valid,
    output dct_math_pkg::dct_out_t coef_data,
    input  logic                   coef_credit
);

    dct_link_if lnk ();

    // Pixels in, row vectors out
    row_transform i_row_transform (
        .clk        (clk),
        .rst        (rst),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .pix_credit (pix_credit),
        .lnk        (lnk.row_src)
    );

    column_transform i_column_transform (
        .clk     (clk),
        .rst     (rst),
        .lnk_row (lnk.row_dst),
        .lnk_blk (lnk.blk_src)
    );

    // Finished blocks out as a coefficient stream
    coef_stream_out i_coef_stream_out (
        .clk         (clk),
        .rst         (rst),
        .coef_valid  (coef_valid),
        .coef_data   (coef_data),
        .coef_credit (coef_credit),
        .lnk         (lnk.blk_dst)
    );

endmodule

`default_nettype wire

// File: verif/dct_tb.sv
`default_nettype none

`include "dct_params.svh"

module dct_tb;
    import dct_math_pkg::*;

    localparam int  BLK         = `DCT_N * `DCT_N;
    localparam int  NUM_BLOCKS  = 14;
    localparam int  WATCHDOG    = NUM_BLOCKS * BLK * 4 + 2000;
    localparam int  HOLD_CYCLES = 800;
    localparam int  MAX_AHEAD   = (`DCT_BANKS + 1) * BLK;
    localparam real PI          = 3.14159265358979;

    logic     clk;
    logic     rst;
    logic     pix_valid;
    pixel_t   pix_data;
    logic     pix_credit;
    logic     coef_valid;
    dct_out_t coef_data;
    logic     coef_credit;

    integer   seed;
    int       errors;
    int       tests;
    int       tbl [`DCT_N][`DCT_N];
    int       blk [BLK];
    int       pix_q [$];
    dct_out_t exp_q [$];
    dct_out_t exp_coef;
    logic     exp_avail;
    int       src_credits;
    int       sink_out;
    int       credited;
    int       coef_cnt;
    logic     sink_en;
    logic     flat_mode;

    dct_top i_dct_top (
        .clk         (clk),
        .rst         (rst),
        .pix_valid   (pix_valid),
        .pix_data    (pix_data),
        .pix_credit  (pix_credit),
        .coef_valid  (coef_valid),
        .coef_data   (coef_data),
        .coef_credit (coef_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int round_real(real x);
        return (x >= 0.0) ? $rtoi(x + 0.5) : -$rtoi(0.5 - x);
    endfunction

    // Drop d bits and add one when the top dropped bit is set
    function automatic int round_drop(int s, int d);
        return (s >>> d) + ((s >>> (d - 1)) & 1);
    endfunction

    task automatic build_table();
        for (int k = 0; k < `DCT_N; k++) begin
            for (int n = 0; n < `DCT_N; n++) begin
                tbl[k][n] = (k == 0) ? 5793
                    : round_real(8192.0 * $cos((2 * n + 1) * k * PI / 16.0));
            end
        end
    endtask

    task automatic fill_flat(int p);
        for (int i = 0; i < BLK; i++) begin
            blk[i] = p;
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < BLK; i++) begin
            blk[i] = $random(seed) & 255;
        end
    endtask

    // Queue the model's coefficients and then the block's pixels
    task automatic queue_block();
        int y [`DCT_N][`DCT_N];
        int s;
        for (int r = 0; r < `DCT_N; r++) begin
            for (int k = 0; k < `DCT_N; k++) begin
                s = 0;
                for (int n = 0; n < `DCT_N; n++) begin
                    s += (blk[r*`DCT_N+n] - 128) * tbl[k][n];
                end
                y[r][k] = round_drop(s, `DCT_ROW_DROP);
            end
        end
        for (int v = 0; v < `DCT_N; v++) begin
            for (int u = 0; u < `DCT_N; u++) begin
                s = 0;
                for (int r = 0; r < `DCT_N; r++) begin
                    s += tbl[v][r] * y[r][u];
                end
                exp_q.push_back(dct_out_t'(round_drop(s, `DCT_COL_DROP)));
            end
        end
        for (int i = 0; i < BLK; i++) begin
            pix_q.push_back(blk[i]);
        end
    endtask

    task automatic end_test(string name, int first_err);
        while (exp_q.size() != 0 || pix_q.size() != 0) begin
            @(negedge clk);
        end
        tests++;
        $display("test %-10s done, %0d failed checks", name, errors - first_err);
    endtask

    // Source and sink drive the DUT on the falling edge
    always @(negedge clk) begin
        pix_valid   = 1'b0;
        coef_credit = 1'b0;
        if (!rst) begin
            if (src_credits > 0 && pix_q.size() != 0 && ($random(seed) & 3) != 0) begin
                pix_valid = 1'b1;
                pix_data  = pixel_t'(pix_q.pop_front());
            end
            coef_credit = sink_en && (sink_out < `DCT_OUT_CREDITS) && ($random(seed) & 1);
        end
        exp_avail = (exp_q.size() != 0);
        if (exp_avail) begin
            exp_coef = exp_q[0];
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            src_credits <= 0;
            sink_out    <= 0;
            credited    <= 0;
            coef_cnt    <= 0;
        end else begin
            src_credits <= src_credits + int'(pix_credit) - int'(pix_valid);
            sink_out    <= sink_out + int'(coef_credit) - int'(coef_valid);
            credited    <= credited + int'(pix_credit);
            if (coef_valid) begin
                coef_cnt <= coef_cnt + 1;
                exp_q.delete(0);
            end
        end
    end

    assert property (@(posedge clk) rst |-> !pix_credit && !coef_valid)
        else begin
            errors++;
            $display("Credit or coefficient output active during reset at time %0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst) coef_valid && exp_avail |->
        coef_data == exp_coef)
        else begin
            errors++;
            $display("ERROR %0t: coefficient %0d is %0d, expected %0d", $time,
                     $sampled(coef_cnt) % BLK, $sampled(coef_data), $sampled(exp_coef));
        end

    // Flat blocks carry energy only in DC
    assert property (@(posedge clk) disable iff (rst)
        coef_valid && flat_mode && (coef_cnt % BLK) != 0 |-> coef_data == '0)
        else begin
            errors++;
            $display("ERROR %0t: flat block AC coefficient %0d is %0d", $time,
                     $sampled(coef_cnt) % BLK, $sampled(coef_data));
        end

    assert property (@(posedge clk) disable iff (rst) coef_valid |-> exp_avail)
        else begin
            errors++;
            $display("A coefficient arrived when none was expected at time %0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst) coef_valid |-> sink_out > 0)
        else begin
            errors++;
            $display("A coefficient was sent without an output credit at time %0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst) src_credits <= `DCT_IN_CREDITS)
        else begin
            errors++;
            $display("More than %0d input credits were outstanding at time %0t",
                     `DCT_IN_CREDITS, $time);
        end

    assert property (@(posedge clk) disable iff (rst)
        credited <= (coef_cnt / BLK) * BLK + MAX_AHEAD)
        else begin
            errors++;
            $display("More than %0d pixels were credited ahead of delivered blocks at time %0t",
                     MAX_AHEAD, $time);
        end

    initial begin
        int err_start;
        seed        = 79;
        rst         = 1'b1;
        pix_valid   = 1'b0;
        pix_data    = '0;
        coef_credit = 1'b0;
        sink_en     = 1'b1;
        flat_mode   = 1'b0;
        exp_avail   = 1'b0;
        exp_coef    = '0;
        errors      = 0;
        tests       = 0;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        end_test("reset", 0);

        err_start = errors;
        @(posedge clk);
        flat_mode = 1'b1;
        fill_flat(128);
        queue_block();
        end_test("flat_128", err_start);

        err_start = errors;
        @(posedge clk);
        fill_flat(0);
        queue_block();
        fill_flat(255);
        queue_block();
        fill_flat($random(seed) & 255);
        queue_block();
        end_test("flat_dc", err_start);
        flat_mode = 1'b0;

        err_start = errors;
        @(posedge clk);
        for (int b = 0; b < 6; b++) begin
            fill_random();
            queue_block();
        end
        end_test("random", err_start);

        // The input side has to stall while the output is starved
        err_start = errors;
        @(posedge clk);
        sink_en = 1'b0;
        for (int b = 0; b < 4; b++) begin
            fill_random();
            queue_block();
        end
        repeat (HOLD_CYCLES) @(posedge clk);
        assert (pix_q.size() != 0)
            else begin
                errors++;
                $display("Input kept taking pixels while output credits were held back");
            end
        sink_en = 1'b1;
        end_test("no_credit", err_start);

        $display("Tests run %0d, failed checks %0d", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Timeout after %0d cycles with %0d coefficients still expected",
                 WATCHDOG, exp_q.size());
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
logic/dct_math_pkg.sv
logic/dct_flow_pkg.sv
logic/dct_link_if.sv
logic/row_transform.sv
logic/column_transform.sv
logic/coef_stream_out.sv
logic/dct_top.sv
verif/dct_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dct_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
